// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINT      ?= --lint-only -Wall --timing
TOP       ?= dvb_tx_tb
RTL_TOP   ?= dvb_tx_top
FILELIST  ?= dvb_tx.f
PASS_MSG  := all tests passed

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== dvb_tx.f ====
dvb_tx_pkg.sv
dvb_tx_cfg_if.sv
dvb_tx_cfg_regs.sv
dvb_tx_symbol_mapper.sv
dvb_tx_interp.sv
dvb_tx_top.sv
dvb_tx_assertions.sv
dvb_tx_tb.sv

// ==== dvb_tx_assertions.sv ====
`default_nettype none

module dvb_tx_assertions #(
	parameter bit on_interp = 1'b0
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic sym_oe,
	input wire logic sym2x_oe,
	input wire logic ts_busy,
	input wire dvb_tx_pkg::map_state_t state,
	input wire dvb_tx_pkg::baud_div_t baud_div
);
	import dvb_tx_pkg::*;

	generate
		if (on_interp) begin : g_interp
			pair_after_symbol: assert property (@(posedge clk) disable iff (!rst_n)
				sym_oe |=> sym2x_oe ##1 sym2x_oe) else $error("sym2x_oe pair missing");
			no_stray_sample: assert property (@(posedge clk) disable iff (!rst_n)
				sym2x_oe |-> $past(sym_oe) || $past(sym_oe, 2)) else $error("stray sym2x_oe");
		end else begin : g_mapper
			baud_div_t gap; // clocks since the last symbol
			logic more; // last symbol was not the final one of its byte

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					gap <= '0;
					more <= 1'b0;
				end else if (sym_oe) begin
					gap <= baud_div_t'(1);
					more <= (state == shifting);
				end else begin
					gap <= gap + baud_div_t'(1);
				end
			end

			busy_on_symbol: assert property (@(posedge clk) disable iff (!rst_n)
				sym_oe |-> $past(ts_busy)) else $error("sym_oe without ts_busy before it");
			baud_interval: assert property (@(posedge clk) disable iff (!rst_n)
				sym_oe && more |-> gap == baud_div) else $error("symbol interval wrong");
		end
	endgenerate

endmodule

bind dvb_tx_symbol_mapper dvb_tx_assertions #(.on_interp(1'b0)) mapper_checks (
	.clk(clk),
	.rst_n(rst_n),
	.sym_oe(sym_oe),
	.sym2x_oe(1'b0),
	.ts_busy(ts_busy),
	.state(state),
	.baud_div(cfg.baud_div)
);

bind dvb_tx_interp dvb_tx_assertions #(.on_interp(1'b1)) interp_checks (
	.clk(clk),
	.rst_n(rst_n),
	.sym_oe(sym_oe),
	.sym2x_oe(sym2x_oe),
	.ts_busy(1'b0),
	.state(dvb_tx_pkg::idle),
	.baud_div(16'd0)
);

`default_nettype wire

// ==== dvb_tx_cfg_if.sv ====
`default_nettype none

interface dvb_tx_cfg_if;
	import dvb_tx_pkg::*;

	mod_mode_t mod_mode;
	logic freq_inv; // swap I and Q
	baud_div_t baud_div;
	logic tx_enable;

	modport source (
		output mod_mode, freq_inv, baud_div, tx_enable
	);

	modport sink (
		input mod_mode, freq_inv, baud_div, tx_enable
	);

endinterface

`default_nettype wire

// ==== dvb_tx_cfg_regs.sv ====
`default_nettype none

module dvb_tx_cfg_regs #(
	parameter int data_width = 32,
	parameter int addr_bits = 4
) (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic wen,
	input wire logic [addr_bits-1:0] waddr,
	input wire logic [data_width-1:0] wdata,
	input wire logic [data_width/8-1:0] wstrb,

	input wire logic ren,
	input wire logic [addr_bits-1:0] raddr,
	output dvb_tx_pkg::reg_data_t rdata,

	dvb_tx_cfg_if.source cfg
);
	import dvb_tx_pkg::*;

	logic stage_wen;
	logic [addr_bits-1:0] stage_addr;
	logic [data_width-1:0] stage_data; // unstrobed bytes keep old contents

	mod_mode_t mod_mode_q;
	logic freq_inv_q;
	baud_div_t baud_div_q;
	logic tx_enable_q;

	// write staging, one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stage_wen <= 1'b0;
			stage_addr <= '0;
			stage_data <= '0;
		end else begin
			stage_wen <= wen;
			if (wen) begin
				stage_addr <= waddr;
				for (int i = 0; i < data_width / 8; i++) begin
					if (wstrb[i]) begin
						stage_data[8*i +: 8] <= wdata[8*i +: 8];
					end
				end
			end
		end
	end

	// commit into the field registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mod_mode_q <= bpsk;
			freq_inv_q <= 1'b0;
			baud_div_q <= '0;
			tx_enable_q <= 1'b0;
		end else if (stage_wen) begin
			case (stage_addr)
				addr_mod_mode: mod_mode_q <= mod_mode_t'(stage_data[0]);
				addr_freq_inv: freq_inv_q <= stage_data[0];
				addr_baud_div: baud_div_q <= stage_data[15:0];
				addr_tx_enable: tx_enable_q <= stage_data[0];
				default: ; // writes elsewhere are dropped
			endcase
		end
	end

	// readback, field only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				addr_mod_mode: rdata <= reg_data_t'(mod_mode_q);
				addr_freq_inv: rdata <= reg_data_t'(freq_inv_q);
				addr_baud_div: rdata <= reg_data_t'(baud_div_q);
				addr_tx_enable: rdata <= reg_data_t'(tx_enable_q);
				default: rdata <= {unmapped_tag, 16'(raddr)};
			endcase
		end
	end

	assign cfg.mod_mode = mod_mode_q;
	assign cfg.freq_inv = freq_inv_q;
	assign cfg.baud_div = baud_div_q;
	assign cfg.tx_enable = tx_enable_q;

endmodule

`default_nettype wire

// ==== dvb_tx_interp.sv ====
`default_nettype none

module dvb_tx_interp (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic sym_oe,
	input wire dvb_tx_pkg::sample_t sym_re,
	input wire dvb_tx_pkg::sample_t sym_im,

	output logic sym2x_oe,
	output dvb_tx_pkg::sample_t sym2x_re,
	output dvb_tx_pkg::sample_t sym2x_im
);
	import dvb_tx_pkg::*;

	sample_t prev_re; // last symbol seen
	sample_t prev_im;
	logic second; // symbol sample still to send

	// one extra bit so +-16384 pairs do not wrap
	logic signed [16:0] sum_re;
	logic signed [16:0] sum_im;

	assign sum_re = prev_re + sym_re;
	assign sum_im = prev_im + sym_im;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sym2x_oe <= 1'b0;
			second <= 1'b0;
			prev_re <= '0;
			prev_im <= '0;
		end else begin
			sym2x_oe <= sym_oe || second;
			second <= sym_oe;
			if (sym_oe) begin
				prev_re <= sym_re;
				prev_im <= sym_im;
			end
		end
	end

	// midpoint first, then the symbol itself
	always_ff @(posedge clk) begin
		if (sym_oe) begin
			sym2x_re <= sum_re[16:1]; // arithmetic halving
			sym2x_im <= sum_im[16:1];
		end else if (second) begin
			sym2x_re <= prev_re;
			sym2x_im <= prev_im;
		end
	end

endmodule

`default_nettype wire

// ==== dvb_tx_pkg.sv ====
`default_nettype none

package dvb_tx_pkg;

	// I or Q value, full scale is 2^14
	typedef logic signed [15:0] sample_t;

	typedef logic [31:0] reg_data_t;

	// clocks per symbol
	typedef logic [15:0] baud_div_t;

	typedef enum logic [0:0] {
		bpsk = 1'b0,
		qpsk = 1'b1
	} mod_mode_t;

	typedef enum logic {
		idle,
		shifting
	} map_state_t;

	localparam int addr_mod_mode  = 0; // 1 bit
	localparam int addr_freq_inv  = 1; // 1 bit
	localparam int addr_baud_div  = 2; // 16 bits, at least 2
	localparam int addr_tx_enable = 3; // 1 bit

	// upper half of the readback for unmapped addresses
	localparam logic [15:0] unmapped_tag = 16'hE000;

	localparam sample_t amp_bpsk = 16'sd16384; // 1.0
	localparam sample_t amp_qpsk = 16'sd11585; // 1/sqrt(2)

endpackage

`default_nettype wire

// ==== dvb_tx_symbol_mapper.sv ====
`default_nettype none

module dvb_tx_symbol_mapper (
	input wire logic clk,
	input wire logic rst_n,

	dvb_tx_cfg_if.sink cfg,

	input wire logic [7:0] ts_data,
	input wire logic ts_valid,
	output logic ts_busy,

	output logic sym_oe,
	output dvb_tx_pkg::sample_t sym_re,
	output dvb_tx_pkg::sample_t sym_im
);
	import dvb_tx_pkg::*;

	map_state_t state;
	baud_div_t baud_cnt;
	logic [3:0] sym_left; // symbols still to send for this byte
	mod_mode_t byte_mode; // mode latched with the byte
	logic [7:0] shift_reg;

	logic accept;
	logic sym_tick;
	sample_t map_i;
	sample_t map_q;

	// busy through the cycle of the last symbol
	assign ts_busy = (state == shifting) || sym_oe;
	assign accept = ts_valid && !ts_busy && cfg.tx_enable;
	assign sym_tick = (baud_cnt == cfg.baud_div - baud_div_t'(1));

	// msb first, a set bit maps to the negative amplitude
	always_comb begin
		if (byte_mode == qpsk) begin
			map_i = shift_reg[7] ? -amp_qpsk : amp_qpsk;
			map_q = shift_reg[6] ? -amp_qpsk : amp_qpsk;
		end else begin
			map_i = shift_reg[7] ? -amp_bpsk : amp_bpsk;
			map_q = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			baud_cnt <= '0;
			sym_left <= '0;
			byte_mode <= bpsk;
			sym_oe <= 1'b0;
		end else begin
			sym_oe <= 1'b0;
			case (state)
				idle: begin
					if (accept) begin
						state <= shifting;
						baud_cnt <= baud_div_t'(1); // first symbol baud_div clocks out
						sym_left <= (cfg.mod_mode == qpsk) ? 4'd4 : 4'd8;
						byte_mode <= cfg.mod_mode;
					end
				end
				shifting: begin
					if (sym_tick) begin
						sym_oe <= 1'b1;
						baud_cnt <= '0;
						sym_left <= sym_left - 4'd1;
						if (sym_left == 4'd1) begin
							state <= idle;
						end
					end else begin
						baud_cnt <= baud_cnt + baud_div_t'(1);
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= ts_data;
		end else if (state == shifting && sym_tick) begin
			shift_reg <= (byte_mode == qpsk) ? {shift_reg[5:0], 2'b00} : {shift_reg[6:0], 1'b0};
			sym_re <= cfg.freq_inv ? map_q : map_i; // spectrum inversion
			sym_im <= cfg.freq_inv ? map_i : map_q;
		end
	end

endmodule

`default_nettype wire

// ==== dvb_tx_tb.sv ====
`default_nettype none

module dvb_tx_tb;
	import dvb_tx_pkg::*;

	logic clk;
	logic rst_n;
	logic wen;
	logic [3:0] waddr;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic ren;
	logic [3:0] raddr;
	reg_data_t rdata;
	logic [7:0] ts_data;
	logic ts_valid;
	logic ts_busy;
	logic sym_oe;
	sample_t sym_re;
	sample_t sym_im;
	logic sym2x_oe;
	sample_t sym2x_re;
	sample_t sym2x_im;

	// shadow of the register bank
	logic [31:0] stage_m;
	logic mode_m;
	logic inv_m;
	logic [15:0] baud_m;
	logic en_m;
	int prev_re; // last symbol seen by the interpolator
	int prev_im;

	dvb_tx_top #(.data_width(32), .addr_bits(4)) dvb_tx_top_inst (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.ts_data(ts_data), .ts_valid(ts_valid), .ts_busy(ts_busy),
		.sym_oe(sym_oe), .sym_re(sym_re), .sym_im(sym_im),
		.sym2x_oe(sym2x_oe), .sym2x_re(sym2x_re), .sym2x_im(sym2x_im)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input int exp_v, input int act_v);
		assert (exp_v == act_v) else begin
			$display("[FAIL] time %0t %s expected %0d (%08h) got %0d (%08h)",
				$time, name, exp_v, exp_v, act_v, act_v);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		@(negedge clk);
		while (ts_busy) begin
			t++;
			if (t > 100000) begin
				$display("ts_busy never went low before the next byte");
				$display("tests failed");
				$fatal(1);
			end
			@(negedge clk);
		end
	endtask

	task automatic write_reg(input logic [31:0] a, input logic [31:0] s, input logic [31:0] d);
		@(posedge clk);
		wen <= 1'b1;
		waddr <= a[3:0];
		wstrb <= s[3:0];
		wdata <= d;
		@(posedge clk);
		wen <= 1'b0;
		repeat (2) @(posedge clk); // staged, then committed
		for (int i = 0; i < 4; i++) begin
			if (s[i]) stage_m[8*i +: 8] = d[8*i +: 8];
		end
		case (a)
			0: mode_m = stage_m[0];
			1: inv_m = stage_m[0];
			2: baud_m = stage_m[15:0];
			3: en_m = stage_m[0];
			default: ;
		endcase
	endtask

	task automatic read_reg(input logic [31:0] a, input logic [31:0] exp_v);
		@(posedge clk);
		ren <= 1'b1;
		raddr <= a[3:0];
		@(posedge clk);
		ren <= 1'b0;
		@(negedge clk);
		check_value("rdata", exp_v, rdata);
	endtask

	// msb first, a set bit gives the negative amplitude
	task automatic map_symbol(input logic [7:0] b, input int j, output int re, output int im);
		int i_v;
		int q_v;
		if (mode_m) begin
			i_v = b[7 - 2*j] ? -11585 : 11585;
			q_v = b[6 - 2*j] ? -11585 : 11585;
		end else begin
			i_v = b[7 - j] ? -16384 : 16384;
			q_v = 0;
		end
		re = inv_m ? q_v : i_v;
		im = inv_m ? i_v : q_v;
	endtask

	task automatic send_byte(input logic [7:0] b);
		int n;
		int bd;
		int exp_oe;
		int exp_2x;
		int cur_re;
		int cur_im;
		int mid_re;
		int mid_im;
		wait_idle();
		repeat ($urandom % 4) @(posedge clk);
		@(posedge clk);
		ts_valid <= 1'b1;
		ts_data <= b;
		@(posedge clk); // acceptance edge
		ts_valid <= 1'b0;
		bd = (baud_m < 2) ? 2 : int'(baud_m);
		if (!en_m) begin
			for (int k = 0; k < 20 * bd; k++) begin
				@(negedge clk);
				check_value("sym_oe", 0, sym_oe);
			end
			return;
		end
		n = mode_m ? 4 : 8;
		// k counts cycles after the one in which the byte was taken
		for (int k = 1; k <= n * bd + 2; k++) begin
			@(negedge clk);
			check_value("ts_busy", int'(k <= n * bd), ts_busy);
			exp_2x = 0;
			if (k > bd && (k - 1) % bd == 0 && (k - 1) / bd <= n) begin
				check_value("sym2x_re", mid_re, sym2x_re);
				check_value("sym2x_im", mid_im, sym2x_im);
				exp_2x = 1;
			end else if (k > bd + 1 && (k - 2) % bd == 0 && (k - 2) / bd <= n) begin
				check_value("sym2x_re", cur_re, sym2x_re);
				check_value("sym2x_im", cur_im, sym2x_im);
				exp_2x = 1;
			end
			check_value("sym2x_oe", exp_2x, sym2x_oe);
			exp_oe = int'(k > 0 && k % bd == 0 && k <= n * bd);
			check_value("sym_oe", exp_oe, sym_oe);
			if (exp_oe != 0) begin
				map_symbol(b, k / bd - 1, cur_re, cur_im);
				check_value("sym_re", cur_re, sym_re);
				check_value("sym_im", cur_im, sym_im);
				mid_re = (prev_re + cur_re) >>> 1;
				mid_im = (prev_im + cur_im) >>> 1;
				prev_re = cur_re;
				prev_im = cur_im;
			end
		end
	endtask

	initial begin
		int fd;
		int rc;
		string line;
		logic [7:0] cmd;
		logic [31:0] a;
		logic [31:0] s;
		logic [31:0] d;
		void'($urandom(26));
		clk = 1'b0;
		rst_n = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		wstrb = '0;
		ren = 1'b0;
		raddr = '0;
		ts_data = '0;
		ts_valid = 1'b0;
		stage_m = '0;
		mode_m = 1'b0;
		inv_m = 1'b0;
		baud_m = '0;
		en_m = 1'b0;
		prev_re = 0;
		prev_im = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		fd = $fopen("dvb_tx_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			$display("tests failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			cmd = 8'h00;
			rc = $fgets(line, fd);
			rc = $sscanf(line, "%c %h %h %h", cmd, a, s, d);
			case (cmd)
				"W": write_reg(a, s, d);
				"R": read_reg(a, s); // second column is the expected word
				"B": send_byte(a[7:0]);
				default: ; // comments and blank lines
			endcase
		end
		$fclose(fd);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dvb_tx_testdata.txt ====
# W addr strobe data | R addr expected | B byte, all fields hex
# reset values and unmapped addresses
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 5 E0000005
R F E000000F
# partial strobes on baud_div, staged bytes are kept
W 2 F 12345678
R 2 00005678
W 2 1 AAAAAA04
R 2 00005604
W 2 2 00000300
R 2 00000304
W 2 C FFFF0000
R 2 00000304
W 2 2 00000000
R 2 00000004
# qpsk, enabled
W 0 1 00000001
W 3 1 00000001
R 0 00000001
R 3 00000001
B 1B
B E4
B 00
# bpsk
W 0 1 00000000
B A5
# qpsk with I and Q swapped, then the shortest baud period
W 0 1 00000001
W 1 1 00000001
R 1 00000001
B 36
W 2 3 00000002
B C9
# transmit disabled, byte must be dropped
W 3 1 00000000
B FF
R 3 00000000

// ==== dvb_tx_top.sv ====
`default_nettype none

module dvb_tx_top #(
	parameter int data_width = 32,
	parameter int addr_bits = 4
) (
	input wire logic clk,
	input wire logic rst_n,

	// host bus
	input wire logic wen,
	input wire logic [addr_bits-1:0] waddr,
	input wire logic [data_width-1:0] wdata,
	input wire logic [data_width/8-1:0] wstrb,
	input wire logic ren,
	input wire logic [addr_bits-1:0] raddr,
	output dvb_tx_pkg::reg_data_t rdata,

	// transport stream bytes
	input wire logic [7:0] ts_data,
	input wire logic ts_valid,
	output logic ts_busy,

	// one sample per symbol
	output logic sym_oe,
	output dvb_tx_pkg::sample_t sym_re,
	output dvb_tx_pkg::sample_t sym_im,

	// two samples per symbol
	output logic sym2x_oe,
	output dvb_tx_pkg::sample_t sym2x_re,
	output dvb_tx_pkg::sample_t sym2x_im
);

	dvb_tx_cfg_if cfg_if ();

	dvb_tx_cfg_regs #(
		.data_width(data_width),
		.addr_bits(addr_bits)
	) dvb_tx_cfg_regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.cfg(cfg_if.source)
	);

	dvb_tx_symbol_mapper dvb_tx_symbol_mapper_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg_if.sink),
		.ts_data(ts_data),
		.ts_valid(ts_valid),
		.ts_busy(ts_busy),
		.sym_oe(sym_oe),
		.sym_re(sym_re),
		.sym_im(sym_im)
	);

	dvb_tx_interp dvb_tx_interp_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sym_oe(sym_oe),
		.sym_re(sym_re),
		.sym_im(sym_im),
		.sym2x_oe(sym2x_oe),
		.sym2x_re(sym2x_re),
		.sym2x_im(sym2x_im)
	);

endmodule

`default_nettype wire
